// ==== verilog.f ====
+incdir+source
source/mcPkg.sv
source/slotTable.sv
source/readIssue.sv
source/writeIssue.sv
source/memController.sv
bench/mcChecker.sv
bench/memControllerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module memControllerTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== bench/memControllerTb.sv ====
`include "mcParams.svh"

module memControllerTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mcPkg::*;

    localparam int NUM_TESTS = 17;
    localparam int HOLD_FIRST = 6;
    localparam int HOLD_LAST = 9;
    localparam int OOO_FIRST = 10;
    localparam int TIMEOUT = 300;

    typedef struct {
        string name;
        int port;
        mcCmd_t cmd;
        logic [31:0] addr;
        logic [31:0] data;
        logic [7:0] tag;
        logic [31:0] expData;
        logic [2:0] size;
        logic [3:0] strb;
        bit waitDone;
    } entry_t;

    typedef struct packed {
        logic [1:0] id;
        logic [31:0] addr;
    } addrReq_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0] strb;
    } wBeat_t;

    logic clk;
    logic rst;
    mcCmd_t reqCmd [`MC_NUM_PORTS-1:0];
    logic [31:0] reqAddr [`MC_NUM_PORTS-1:0];
    logic [31:0] reqData [`MC_NUM_PORTS-1:0];
    logic [7:0] reqTag [`MC_NUM_PORTS-1:0];
    logic [`MC_NUM_PORTS-1:0] stall;
    logic ldResValid, stResValid;
    logic [7:0] ldResTag, stResTag;
    logic [31:0] ldResData;
    logic [1:0] arId, awId, rId, bId;
    logic [31:0] arAddr, awAddr, wData, rData;
    logic [2:0] arSize, awSize;
    logic [1:0] arBurst, awBurst;
    logic arValid, arReady, awValid, awReady, wValid, wReady, wLast;
    logic [3:0] wStrb;
    logic rValid, rReady, bValid, bReady;
    int outstanding, errors, checks;
    int timeouts;
    int seed;
    bit arHold;
    bit respHold;
    logic [31:0] mem [256];
    addrReq_t rdQ [$];
    addrReq_t awQ [$];
    wBeat_t wQ [$];
    logic [1:0] bQ [$];
    entry_t tests [NUM_TESTS];

    memController uut (
        .clk(clk), .rst(rst),
        .reqCmd(reqCmd), .reqAddr(reqAddr), .reqData(reqData), .reqTag(reqTag),
        .stall(stall),
        .ldResValid(ldResValid), .ldResTag(ldResTag), .ldResData(ldResData),
        .stResValid(stResValid), .stResTag(stResTag),
        .axiArId(arId), .axiArAddr(arAddr), .axiArSize(arSize), .axiArBurst(arBurst),
        .axiArValid(arValid), .axiArReady(arReady),
        .axiAwId(awId), .axiAwAddr(awAddr), .axiAwSize(awSize), .axiAwBurst(awBurst),
        .axiAwValid(awValid), .axiAwReady(awReady),
        .axiWData(wData), .axiWStrb(wStrb), .axiWLast(wLast), .axiWValid(wValid),
        .axiWReady(wReady),
        .axiRId(rId), .axiRData(rData), .axiRValid(rValid), .axiRReady(rReady),
        .axiBId(bId), .axiBValid(bValid), .axiBReady(bReady)
    );

    mcChecker chk (
        .clk(clk), .rst(rst),
        .ldResValid(ldResValid), .ldResTag(ldResTag), .ldResData(ldResData),
        .stResValid(stResValid), .stResTag(stResTag),
        .axiArValid(arValid), .axiArReady(arReady), .axiArAddr(arAddr),
        .axiArSize(arSize), .axiArBurst(arBurst),
        .axiAwValid(awValid), .axiAwReady(awReady), .axiAwSize(awSize),
        .axiAwBurst(awBurst),
        .axiWValid(wValid), .axiWReady(wReady), .axiWStrb(wStrb), .axiWLast(wLast),
        .axiRValid(rValid), .axiBValid(bValid),
        .outstanding(outstanding), .errors(errors), .checks(checks)
    );

    always #50 clk = ~clk;

    // Slave memory records handshakes at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (arValid && arReady)
                rdQ.push_back({arId, arAddr});
            if (awValid && awReady)
                awQ.push_back({awId, awAddr});
            if (wValid && wReady)
                wQ.push_back({wData, wStrb});
            while (awQ.size() > 0 && wQ.size() > 0) begin
                addrReq_t a;
                wBeat_t w;
                a = awQ.pop_front();
                w = wQ.pop_front();
                for (int b = 0; b < 4; b++)
                    if (w.strb[b])
                        mem[a.addr[9:2]][8*b +: 8] = w.data[8*b +: 8];
                bQ.push_back(a.id);
            end
        end
    end

    // Random ready delays and a random pick among pending responses
    always @(posedge clk) begin
        int idx;
        #5;
        rValid = 1'b0;
        bValid = 1'b0;
        arReady = !arHold && (($random(seed) & 3) != 0);
        awReady = ($random(seed) & 3) != 0;
        wReady = ($random(seed) & 3) != 0;
        if (!rst && !respHold && rdQ.size() > 0 && ($random(seed) & 1)) begin
            idx = int'($unsigned($random(seed)) % rdQ.size());
            rId = rdQ[idx].id;
            rData = mem[rdQ[idx].addr[9:2]];
            rValid = 1'b1;
            rdQ.delete(idx);
        end
        if (!rst && !respHold && bQ.size() > 0 && ($random(seed) & 1)) begin
            idx = int'($unsigned($random(seed)) % bQ.size());
            bId = bQ[idx];
            bValid = 1'b1;
            bQ.delete(idx);
        end
    end

    task automatic applyEntry(input entry_t e);
        int cycles;
        if (e.cmd inside {MC_LOAD_BYTE, MC_LOAD_HALF, MC_LOAD_WORD})
            chk.expectLoad(e.name, e.tag, e.addr, e.size, e.expData);
        else
            chk.expectStore(e.name, e.tag, e.size, e.strb);
        @(posedge clk);
        #5;
        reqCmd[e.port] = e.cmd;
        reqAddr[e.port] = e.addr;
        reqData[e.port] = e.data;
        reqTag[e.port] = e.tag;
        cycles = 0;
        @(negedge clk);
        while (stall[e.port] && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (stall[e.port]) begin
            timeouts++;
            $display("Request %s was never accepted", e.name);
        end
        @(posedge clk);
        #5;
        reqCmd[e.port] = MC_NONE;
    endtask

    task automatic waitIdle(input string what);
        int cycles;
        cycles = 0;
        while (outstanding != 0 && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (outstanding != 0) begin
            timeouts++;
            $display("Results after %s never all arrived", what);
        end
    endtask

    initial begin
        int cycles;
        seed = 65822;
        clk = 1'b0;
        rst = 1'b1;
        arHold = 1'b0;
        respHold = 1'b0;
        timeouts = 0;
        arReady = 1'b0;
        awReady = 1'b0;
        wReady = 1'b0;
        rValid = 1'b0;
        bValid = 1'b0;
        rId = '0;
        bId = '0;
        rData = '0;
        for (int p = 0; p < `MC_NUM_PORTS; p++) begin
            reqCmd[p] = MC_NONE;
            reqAddr[p] = '0;
            reqData[p] = '0;
            reqTag[p] = '0;
        end
        // Fill word holds its index and the inverted index
        for (int i = 0; i < 256; i++)
            mem[i] = {i[15:0], ~i[15:0]};

        tests[0] = '{"wordStore", 0, MC_STORE_WORD, 32'h100, 32'hA1B2C3D4, 8'd1, 0, 3'd2, 4'hF, 1};
        tests[1] = '{"wordLoad", 1, MC_LOAD_WORD, 32'h100, 0, 8'd2, 32'hA1B2C3D4, 3'd2, 0, 1};
        tests[2] = '{"byteStore", 0, MC_STORE_BYTE, 32'h101, 32'h5E, 8'd3, 0, 3'd0, 4'h2, 1};
        tests[3] = '{"halfStore", 2, MC_STORE_HALF, 32'h102, 32'h7788, 8'd4, 0, 3'd1, 4'hC, 1};
        tests[4] = '{"mergedLoad", 0, MC_LOAD_WORD, 32'h100, 0, 8'd5, 32'h77885ED4, 3'd2, 0, 1};
        tests[5] = '{"byteLoad", 1, MC_LOAD_BYTE, 32'h103, 0, 8'd6, 32'h77885ED4, 3'd0, 0, 1};
        tests[6] = '{"busyLoad0", 0, MC_LOAD_WORD, 32'h080, 0, 8'd10, 32'h0020FFDF, 3'd2, 0, 0};
        tests[7] = '{"busyLoad1", 1, MC_LOAD_WORD, 32'h084, 0, 8'd11, 32'h0021FFDE, 3'd2, 0, 0};
        tests[8] = '{"busyLoad2", 2, MC_LOAD_WORD, 32'h088, 0, 8'd12, 32'h0022FFDD, 3'd2, 0, 0};
        tests[9] = '{"busyLoad3", 0, MC_LOAD_WORD, 32'h08C, 0, 8'd13, 32'h0023FFDC, 3'd2, 0, 0};
        tests[10] = '{"oooLoad0", 0, MC_LOAD_WORD, 32'h040, 0, 8'd14, 32'h0010FFEF, 3'd2, 0, 0};
        tests[11] = '{"oooLoad1", 1, MC_LOAD_WORD, 32'h044, 0, 8'd15, 32'h0011FFEE, 3'd2, 0, 0};
        tests[12] = '{"oooLoad2", 2, MC_LOAD_HALF, 32'h04A, 0, 8'd16, 32'h0012FFED, 3'd1, 0, 0};
        tests[13] = '{"oooLoad3", 0, MC_LOAD_WORD, 32'h04C, 0, 8'd17, 32'h0013FFEC, 3'd2, 0, 1};
        tests[14] = '{"oooStore0", 0, MC_STORE_WORD, 32'h060, 32'h13572468, 8'd30, 0, 3'd2, 4'hF,
                      0};
        tests[15] = '{"oooStore1", 1, MC_STORE_BYTE, 32'h065, 32'h9A, 8'd31, 0, 3'd0, 4'h2, 0};
        tests[16] = '{"oooStore2", 2, MC_STORE_HALF, 32'h06A, 32'hBCDE, 8'd32, 0, 3'd1, 4'hC, 1};

        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        chk.compare("resetValids", 32'h0,
                    {27'd0, arValid, awValid, wValid, ldResValid, stResValid});
        chk.compare("resetStall", 32'h7, {29'd0, stall});
        chk.compare("resetReady", 32'h3, {30'd0, rReady, bReady});

        for (int i = 0; i < NUM_TESTS; i++) begin
            arHold = (i >= HOLD_FIRST && i <= HOLD_LAST);
            // Responses wait until the whole group is accepted
            respHold = (i >= OOO_FIRST);
            applyEntry(tests[i]);
            if (i == HOLD_LAST) begin
                // All four slots wait on AR now
                reqCmd[1] = MC_LOAD_WORD;
                reqAddr[1] = 32'h090;
                @(negedge clk);
                chk.compare("allBusyStall", 32'h7, {29'd0, stall});
                @(posedge clk);
                #5;
                reqCmd[1] = MC_NONE;
                arHold = 1'b0;
                waitIdle(tests[i].name);
            end else if (tests[i].waitDone) begin
                respHold = 1'b0;
                waitIdle(tests[i].name);
            end
        end

        // Ports 0 and 2 request together
        chk.expectLoad("sameCycle0", 8'd20, 32'h00C, 3'd2, 32'h0003FFFC);
        chk.expectLoad("sameCycle2", 8'd21, 32'h010, 3'd2, 32'h0004FFFB);
        @(posedge clk);
        #5;
        reqCmd[0] = MC_LOAD_WORD;
        reqAddr[0] = 32'h00C;
        reqTag[0] = 8'd20;
        reqCmd[2] = MC_LOAD_WORD;
        reqAddr[2] = 32'h010;
        reqTag[2] = 8'd21;
        @(negedge clk);
        chk.compare("sameCycleStall", 32'h6, {29'd0, stall});
        @(posedge clk);
        #5;
        reqCmd[0] = MC_NONE;
        cycles = 0;
        @(negedge clk);
        while (stall[2] && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (stall[2]) begin
            timeouts++;
            $display("Port 2 request was never accepted");
        end
        @(posedge clk);
        #5;
        reqCmd[2] = MC_NONE;
        waitIdle("sameCycle");

        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== bench/mcChecker.sv ====
`include "mcParams.svh"

module mcChecker (
    input  logic clk,
    input  logic rst,
    input  logic ldResValid,
    input  logic [`MC_TAG_W-1:0] ldResTag,
    input  logic [`MC_DATA_W-1:0] ldResData,
    input  logic stResValid,
    input  logic [`MC_TAG_W-1:0] stResTag,
    input  logic axiArValid,
    input  logic axiArReady,
    input  logic [`MC_ADDR_W-1:0] axiArAddr,
    input  logic [2:0] axiArSize,
    input  logic [1:0] axiArBurst,
    input  logic axiAwValid,
    input  logic axiAwReady,
    input  logic [2:0] axiAwSize,
    input  logic [1:0] axiAwBurst,
    input  logic axiWValid,
    input  logic axiWReady,
    input  logic [`MC_DATA_W/8-1:0] axiWStrb,
    input  logic axiWLast,
    input  logic axiRValid,
    input  logic axiBValid,
    output int outstanding,
    output int errors,
    output int checks
);
    timeunit 1ns;
    timeprecision 1ps;

    string expName [256];
    logic [`MC_DATA_W-1:0] expData [256];
    bit pendLoad [256];
    bit pendStore [256];

    // Loads reach AR in the order they were accepted
    string arNames [$];
    logic [31:0] arAddrs [$];
    logic [2:0] arSizes [$];

    // AW and W handshakes follow the order the stores were accepted in
    string awNames [$];
    logic [2:0] awSizes [$];
    string wNames [$];
    logic [3:0] wStrbs [$];

    // Bus responses seen one cycle earlier
    logic rSeen;
    logic bSeen;

    initial begin
        outstanding = 0;
        errors = 0;
        checks = 0;
        rSeen = 1'b0;
        bSeen = 1'b0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic expectLoad(input string name, input logic [7:0] tag, input logic [31:0] addr,
                              input logic [2:0] size, input logic [31:0] data);
        expName[tag] = name;
        expData[tag] = data;
        pendLoad[tag] = 1'b1;
        arNames.push_back(name);
        arAddrs.push_back(addr);
        arSizes.push_back(size);
        outstanding++;
    endtask

    task automatic expectStore(input string name, input logic [7:0] tag, input logic [2:0] size,
                               input logic [3:0] strb);
        expName[tag] = name;
        pendStore[tag] = 1'b1;
        awNames.push_back(name);
        awSizes.push_back(size);
        wNames.push_back(name);
        wStrbs.push_back(strb);
        outstanding++;
    endtask

    always @(negedge clk) begin
        string name;
        if (!rst) begin
            // Each result strobe follows its bus response by exactly one cycle
            if (rSeen || ldResValid)
                compare("loadResultTiming", {31'd0, rSeen}, {31'd0, ldResValid});
            if (bSeen || stResValid)
                compare("storeResultTiming", {31'd0, bSeen}, {31'd0, stResValid});
            rSeen = axiRValid;
            bSeen = axiBValid;

            if (ldResValid) begin
                if (!pendLoad[ldResTag]) begin
                    errors++;
                    $display("Load result came back with unknown tag %0d", ldResTag);
                end else begin
                    compare({expName[ldResTag], " loadData"}, expData[ldResTag], ldResData);
                    pendLoad[ldResTag] = 1'b0;
                    outstanding--;
                end
            end
            if (stResValid) begin
                if (!pendStore[stResTag]) begin
                    errors++;
                    $display("Store result came back with unknown tag %0d", stResTag);
                end else begin
                    checks++;
                    pendStore[stResTag] = 1'b0;
                    outstanding--;
                end
            end
            if (axiArValid && axiArReady) begin
                if (arSizes.size() == 0) begin
                    errors++;
                    $display("Read address handshake with no load expected");
                end else begin
                    name = arNames.pop_front();
                    compare({name, " arAddr"}, arAddrs.pop_front(), axiArAddr);
                    compare({name, " arSize"}, {29'd0, arSizes.pop_front()},
                            {29'd0, axiArSize});
                    compare({name, " arBurst"}, 32'h2, {30'd0, axiArBurst});
                end
            end
            if (axiAwValid && axiAwReady) begin
                if (awSizes.size() == 0) begin
                    errors++;
                    $display("Write address handshake with no store expected");
                end else begin
                    name = awNames.pop_front();
                    compare({name, " awSize"}, {29'd0, awSizes.pop_front()},
                            {29'd0, axiAwSize});
                    compare({name, " awBurst"}, 32'h2, {30'd0, axiAwBurst});
                end
            end
            if (axiWValid && axiWReady) begin
                if (wStrbs.size() == 0) begin
                    errors++;
                    $display("Write data handshake with no store expected");
                end else begin
                    name = wNames.pop_front();
                    compare({name, " wStrb"}, {28'd0, wStrbs.pop_front()}, {28'd0, axiWStrb});
                    compare({name, " wLast"}, 32'h1, {31'd0, axiWLast});
                end
            end
        end
    end

endmodule

// ==== source/memController.sv ====
`include "mcParams.svh"

module memController (
    input  logic clk,
    input  logic rst,
    input  mcPkg::mcCmd_t reqCmd [`MC_NUM_PORTS-1:0],
    input  logic [`MC_ADDR_W-1:0] reqAddr [`MC_NUM_PORTS-1:0],
    input  logic [`MC_DATA_W-1:0] reqData [`MC_NUM_PORTS-1:0],
    input  logic [`MC_TAG_W-1:0] reqTag [`MC_NUM_PORTS-1:0],
    output logic [`MC_NUM_PORTS-1:0] stall,
    output logic ldResValid,
    output logic [`MC_TAG_W-1:0] ldResTag,
    output logic [`MC_DATA_W-1:0] ldResData,
    output logic stResValid,
    output logic [`MC_TAG_W-1:0] stResTag,
    output logic [`MC_ID_W-1:0] axiArId,
    output logic [`MC_ADDR_W-1:0] axiArAddr,
    output logic [2:0] axiArSize,
    output logic [1:0] axiArBurst,
    output logic axiArValid,
    input  logic axiArReady,
    output logic [`MC_ID_W-1:0] axiAwId,
    output logic [`MC_ADDR_W-1:0] axiAwAddr,
    output logic [2:0] axiAwSize,
    output logic [1:0] axiAwBurst,
    output logic axiAwValid,
    input  logic axiAwReady,
    output logic [`MC_DATA_W-1:0] axiWData,
    output logic [`MC_DATA_W/8-1:0] axiWStrb,
    output logic axiWLast,
    output logic axiWValid,
    input  logic axiWReady,
    input  logic [`MC_ID_W-1:0] axiRId,
    input  logic [`MC_DATA_W-1:0] axiRData,
    input  logic axiRValid,
    output logic axiRReady,
    input  logic [`MC_ID_W-1:0] axiBId,
    input  logic axiBValid,
    output logic axiBReady
);
    import mcPkg::*;

    mcCmd_t slotCmd [`MC_NUM_SLOTS-1:0];
    logic [`MC_ADDR_W-1:0] slotAddr [`MC_NUM_SLOTS-1:0];
    mcOperand_t slotOperand [`MC_NUM_SLOTS-1:0];
    logic [`MC_NUM_SLOTS-1:0] needRead;
    logic [`MC_NUM_SLOTS-1:0] needAw;
    logic [`MC_NUM_SLOTS-1:0] needW;
    logic arDone;
    logic [`MC_ID_W-1:0] arSlot;
    logic awDone;
    logic wDone;
    logic [`MC_ID_W-1:0] writeSlot;

    // Responses are always taken, slots have room for them
    assign axiRReady = 1'b1;
    assign axiBReady = 1'b1;

    slotTable slots (
        .clk(clk), .rst(rst),
        .reqCmd(reqCmd), .reqAddr(reqAddr), .reqData(reqData), .reqTag(reqTag),
        .stall(stall),
        .arDone(arDone), .arSlot(arSlot),
        .awDone(awDone), .wDone(wDone), .writeSlot(writeSlot),
        .axiRId(axiRId), .axiRData(axiRData), .axiRValid(axiRValid),
        .axiBId(axiBId), .axiBValid(axiBValid),
        .slotCmd(slotCmd), .slotAddr(slotAddr), .slotOperand(slotOperand),
        .needRead(needRead), .needAw(needAw), .needW(needW),
        .ldResValid(ldResValid), .ldResTag(ldResTag), .ldResData(ldResData),
        .stResValid(stResValid), .stResTag(stResTag)
    );

    readIssue rdIssue (
        .slotCmd(slotCmd), .slotAddr(slotAddr), .slotOperand(slotOperand),
        .needRead(needRead), .axiArReady(axiArReady),
        .axiArId(axiArId), .axiArAddr(axiArAddr), .axiArSize(axiArSize),
        .axiArBurst(axiArBurst), .axiArValid(axiArValid),
        .arDone(arDone), .arSlot(arSlot)
    );

    writeIssue wrIssue (
        .clk(clk), .rst(rst),
        .slotCmd(slotCmd), .slotAddr(slotAddr), .slotOperand(slotOperand),
        .needAw(needAw), .needW(needW),
        .axiAwReady(axiAwReady), .axiWReady(axiWReady),
        .axiAwId(axiAwId), .axiAwAddr(axiAwAddr), .axiAwSize(axiAwSize),
        .axiAwBurst(axiAwBurst), .axiAwValid(axiAwValid),
        .axiWData(axiWData), .axiWStrb(axiWStrb), .axiWLast(axiWLast),
        .axiWValid(axiWValid),
        .awDone(awDone), .wDone(wDone), .writeSlot(writeSlot)
    );

endmodule

// ==== source/writeIssue.sv ====
`include "mcParams.svh"

module writeIssue (
    input  logic clk,
    input  logic rst,
    input  mcPkg::mcCmd_t slotCmd [`MC_NUM_SLOTS-1:0],
    input  logic [`MC_ADDR_W-1:0] slotAddr [`MC_NUM_SLOTS-1:0],
    input  mcPkg::mcOperand_t slotOperand [`MC_NUM_SLOTS-1:0],
    input  logic [`MC_NUM_SLOTS-1:0] needAw,
    input  logic [`MC_NUM_SLOTS-1:0] needW,
    input  logic axiAwReady,
    input  logic axiWReady,
    output logic [`MC_ID_W-1:0] axiAwId,
    output logic [`MC_ADDR_W-1:0] axiAwAddr,
    output logic [2:0] axiAwSize,
    output logic [1:0] axiAwBurst,
    output logic axiAwValid,
    output logic [`MC_DATA_W-1:0] axiWData,
    output logic [`MC_DATA_W/8-1:0] axiWStrb,
    output logic axiWLast,
    output logic axiWValid,
    output logic awDone,
    output logic wDone,
    output logic [`MC_ID_W-1:0] writeSlot
);
    import mcPkg::*;

    localparam int STRB_W = `MC_DATA_W / 8;
    localparam int OFS_W = $clog2(STRB_W);

    logic holdValid;
    logic [`MC_ID_W-1:0] holdSlot;
    logic [`MC_ID_W-1:0] lowSlot;
    logic lowValid;
    logic selValid;
    logic finished;
    logic [2:0] size;
    logic [`MC_ADDR_W-1:0] alignedAddr;
    logic [`MC_DATA_W-1:0] storeData;
    logic [`MC_DATA_W-1:0] replData;
    logic [STRB_W-1:0] sizeMask;

    always_comb begin
        lowSlot = '0;
        lowValid = 1'b0;
        for (int i = 0; i < `MC_NUM_SLOTS; i++) begin
            if (!lowValid && (needAw[i] || needW[i])) begin
                lowSlot = i[`MC_ID_W-1:0];
                lowValid = 1'b1;
            end
        end
    end

    // Stay on one slot until both AW and W are through, keeps W in AW order
    assign writeSlot = holdValid ? holdSlot : lowSlot;
    assign selValid = holdValid || lowValid;

    assign axiAwValid = selValid && needAw[writeSlot];
    assign axiWValid = selValid && needW[writeSlot];
    assign awDone = axiAwValid && axiAwReady;
    assign wDone = axiWValid && axiWReady;
    assign finished = (awDone || !needAw[writeSlot]) && (wDone || !needW[writeSlot]);

    always_ff @(posedge clk) begin
        if (rst)
            holdValid <= 1'b0;
        else
            holdValid <= selValid && !finished;
    end

    always_ff @(posedge clk) begin
        holdSlot <= writeSlot;
    end

    assign size = cmdSize(slotCmd[writeSlot]);
    assign alignedAddr = alignAddr(slotAddr[writeSlot], size);
    assign storeData = slotOperand[writeSlot].storeData;

    // Narrow stores repeat the data on every lane
    always_comb begin
        case (size)
            3'd0: begin
                sizeMask = {{(STRB_W-1){1'b0}}, 1'b1};
                replData = {STRB_W{storeData[7:0]}};
            end
            3'd1: begin
                sizeMask = {{(STRB_W-2){1'b0}}, 2'b11};
                replData = {(STRB_W/2){storeData[15:0]}};
            end
            default: begin
                sizeMask = '1;
                replData = storeData;
            end
        endcase
    end

    assign axiAwId = axiAwValid ? writeSlot : '0;
    assign axiAwAddr = axiAwValid ? alignedAddr : '0;
    assign axiAwSize = axiAwValid ? size : '0;
    assign axiAwBurst = axiAwValid ? `MC_BURST_WRAP : 2'd0;

    assign axiWData = axiWValid ? replData : '0;
    assign axiWStrb = axiWValid ? (sizeMask << alignedAddr[OFS_W-1:0]) : '0;
    assign axiWLast = axiWValid;

endmodule

// ==== source/readIssue.sv ====
`include "mcParams.svh"

module readIssue (
    input  mcPkg::mcCmd_t slotCmd [`MC_NUM_SLOTS-1:0],
    input  logic [`MC_ADDR_W-1:0] slotAddr [`MC_NUM_SLOTS-1:0],
    input  mcPkg::mcOperand_t slotOperand [`MC_NUM_SLOTS-1:0],
    input  logic [`MC_NUM_SLOTS-1:0] needRead,
    input  logic axiArReady,
    output logic [`MC_ID_W-1:0] axiArId,
    output logic [`MC_ADDR_W-1:0] axiArAddr,
    output logic [2:0] axiArSize,
    output logic [1:0] axiArBurst,
    output logic axiArValid,
    output logic arDone,
    output logic [`MC_ID_W-1:0] arSlot
);
    import mcPkg::*;

    localparam int OFS_W = $clog2(`MC_DATA_W / 8);

    logic [2:0] size;
    logic [`MC_ADDR_W-1:0] fullAddr;

    always_comb begin
        arSlot = '0;
        axiArValid = 1'b0;
        for (int i = 0; i < `MC_NUM_SLOTS; i++) begin
            if (!axiArValid && needRead[i]) begin
                arSlot = i[`MC_ID_W-1:0];
                axiArValid = 1'b1;
            end
        end
    end

    // Word part from the operand, byte lane from the request address
    assign fullAddr = {slotOperand[arSlot].loadAddr[`MC_ADDR_W-1:OFS_W],
                       slotAddr[arSlot][OFS_W-1:0]};
    assign size = cmdSize(slotCmd[arSlot]);

    always_comb begin
        axiArId = '0;
        axiArAddr = '0;
        axiArSize = '0;
        axiArBurst = '0;
        if (axiArValid) begin
            axiArId = arSlot;
            axiArAddr = alignAddr(fullAddr, size);
            axiArSize = size;
            axiArBurst = `MC_BURST_WRAP;
        end
    end

    assign arDone = axiArValid && axiArReady;

endmodule

// ==== source/slotTable.sv ====
`include "mcParams.svh"

module slotTable (
    input  logic clk,
    input  logic rst,
    input  mcPkg::mcCmd_t reqCmd [`MC_NUM_PORTS-1:0],
    input  logic [`MC_ADDR_W-1:0] reqAddr [`MC_NUM_PORTS-1:0],
    input  logic [`MC_DATA_W-1:0] reqData [`MC_NUM_PORTS-1:0],
    input  logic [`MC_TAG_W-1:0] reqTag [`MC_NUM_PORTS-1:0],
    output logic [`MC_NUM_PORTS-1:0] stall,
    input  logic arDone,
    input  logic [`MC_ID_W-1:0] arSlot,
    input  logic awDone,
    input  logic wDone,
    input  logic [`MC_ID_W-1:0] writeSlot,
    input  logic [`MC_ID_W-1:0] axiRId,
    input  logic [`MC_DATA_W-1:0] axiRData,
    input  logic axiRValid,
    input  logic [`MC_ID_W-1:0] axiBId,
    input  logic axiBValid,
    output mcPkg::mcCmd_t slotCmd [`MC_NUM_SLOTS-1:0],
    output logic [`MC_ADDR_W-1:0] slotAddr [`MC_NUM_SLOTS-1:0],
    output mcPkg::mcOperand_t slotOperand [`MC_NUM_SLOTS-1:0],
    output logic [`MC_NUM_SLOTS-1:0] needRead,
    output logic [`MC_NUM_SLOTS-1:0] needAw,
    output logic [`MC_NUM_SLOTS-1:0] needW,
    output logic ldResValid,
    output logic [`MC_TAG_W-1:0] ldResTag,
    output logic [`MC_DATA_W-1:0] ldResData,
    output logic stResValid,
    output logic [`MC_TAG_W-1:0] stResTag
);
    import mcPkg::*;

    localparam int PORT_W = $clog2(`MC_NUM_PORTS);

    logic [`MC_TAG_W-1:0] slotTag [`MC_NUM_SLOTS-1:0];
    logic [`MC_ID_W-1:0] enqIdx;
    logic enqValid;
    logic [`MC_ID_W-1:0] firstRead;
    logic [PORT_W-1:0] selPort;
    logic selValid;
    mcCmd_t selCmd;
    logic [`MC_ADDR_W-1:0] selAddr;
    logic loadBlocked;
    logic accept;

    // Lowest free slot and lowest slot still waiting on AR
    always_comb begin
        enqIdx = '0;
        enqValid = 1'b0;
        firstRead = '0;
        for (int i = 0; i < `MC_NUM_SLOTS; i++) begin
            if (!enqValid && slotCmd[i] == MC_NONE) begin
                enqIdx = i[`MC_ID_W-1:0];
                enqValid = 1'b1;
            end
        end
        for (int i = `MC_NUM_SLOTS - 1; i >= 0; i--) begin
            if (needRead[i])
                firstRead = i[`MC_ID_W-1:0];
        end
    end

    // Fixed priority, port 0 first
    always_comb begin
        selPort = '0;
        selValid = 1'b0;
        for (int p = 0; p < `MC_NUM_PORTS; p++) begin
            if (!selValid && reqCmd[p] != MC_NONE) begin
                selPort = p[PORT_W-1:0];
                selValid = 1'b1;
            end
        end
    end

    assign selCmd = reqCmd[selPort];
    assign selAddr = reqAddr[selPort];

    // A new load below the slot on AR would change the AR address while it waits for ready
    assign loadBlocked = isLoadCmd(selCmd) && (|needRead) && (enqIdx < firstRead);
    assign accept = selValid && enqValid && !loadBlocked;

    always_comb begin
        stall = '1;
        if (accept)
            stall[selPort] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MC_NUM_SLOTS; i++)
                slotCmd[i] <= MC_NONE;
            needRead <= '0;
            needAw <= '0;
            needW <= '0;
            ldResValid <= 1'b0;
            stResValid <= 1'b0;
        end else begin
            ldResValid <= axiRValid;
            stResValid <= axiBValid;

            if (accept) begin
                slotCmd[enqIdx] <= selCmd;
                if (isLoadCmd(selCmd)) begin
                    needRead[enqIdx] <= 1'b1;
                end else begin
                    needAw[enqIdx] <= 1'b1;
                    needW[enqIdx] <= 1'b1;
                end
            end

            if (arDone)
                needRead[arSlot] <= 1'b0;
            if (awDone)
                needAw[writeSlot] <= 1'b0;
            if (wDone)
                needW[writeSlot] <= 1'b0;

            // Single beat bursts, so one response frees the slot
            if (axiRValid)
                slotCmd[axiRId] <= MC_NONE;
            if (axiBValid)
                slotCmd[axiBId] <= MC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slotAddr[enqIdx] <= selAddr;
            slotTag[enqIdx] <= reqTag[selPort];
            if (isLoadCmd(selCmd))
                slotOperand[enqIdx].loadAddr <= selAddr;
            else
                slotOperand[enqIdx].storeData <= reqData[selPort];
        end
        if (axiRValid) begin
            ldResTag <= slotTag[axiRId];
            ldResData <= axiRData;
        end
        if (axiBValid)
            stResTag <= slotTag[axiBId];
    end

endmodule

// ==== source/mcPkg.sv ====
`include "mcParams.svh"

package mcPkg;

    typedef enum logic [2:0] {
        MC_NONE,
        MC_LOAD_BYTE,
        MC_LOAD_HALF,
        MC_LOAD_WORD,
        MC_STORE_BYTE,
        MC_STORE_HALF,
        MC_STORE_WORD
    } mcCmd_t;

    // Slot word holds the load address or the store data
    typedef union packed {
        logic [`MC_ADDR_W-1:0] loadAddr;
        logic [`MC_DATA_W-1:0] storeData;
    } mcOperand_t;

    function automatic logic isLoadCmd(mcCmd_t cmd);
        return cmd inside {MC_LOAD_BYTE, MC_LOAD_HALF, MC_LOAD_WORD};
    endfunction

    // AXI size code, log2 of the access bytes
    function automatic logic [2:0] cmdSize(mcCmd_t cmd);
        case (cmd)
            MC_LOAD_BYTE, MC_STORE_BYTE: return 3'd0;
            MC_LOAD_HALF, MC_STORE_HALF: return 3'd1;
            default: return 3'd2;
        endcase
    endfunction

    // Clear the address bits below the access size
    function automatic logic [`MC_ADDR_W-1:0] alignAddr(logic [`MC_ADDR_W-1:0] addr,
                                                         logic [2:0] size);
        logic [`MC_ADDR_W-1:0] mask;
        mask = ({{(`MC_ADDR_W-1){1'b0}}, 1'b1} << size) - 1'b1;
        return addr & ~mask;
    endfunction

endpackage

// ==== source/mcParams.svh ====
`ifndef MC_PARAMS_SVH
`define MC_PARAMS_SVH

// Transfer slots, one AXI id each
`define MC_NUM_SLOTS 4
`define MC_NUM_PORTS 3
`define MC_ID_W 2

`define MC_ADDR_W 32
`define MC_DATA_W 32
`define MC_TAG_W 8

// AXI burst type driven on AR and AW while valid
`define MC_BURST_WRAP 2'd2

`endif
